// File: hdl/ddr_bridge_pkg.sv
/*
 * shared widths, FIFO sizing and native address step
 * state and opcode enums, request and read beat structs
 */
package ddr_bridge_pkg;

    // native controller and AXI widths
    localparam int addr_w = 27;
    localparam int data_w = 256;
    localparam int id_w   = 4;
    localparam int len_w  = 8;
    // beat count, one more bit than awlen/arlen
    localparam int cnt_w  = len_w + 1;

    // fifo holds a full 256 beat burst
    localparam int fifo_depth = 256;
    localparam int fifo_aw    = 8;

    // native address advance per command
    localparam int app_addr_step = 8;

    // native command codes
    typedef enum logic [2:0] {
        app_write = 3'd0,
        app_read  = 3'd1,
        app_nop   = 3'd7
    } app_opcode_e;

    // bridge FSM states
    typedef enum logic [2:0] {
        calib_wait,
        wr_idle,
        rd_idle,
        wr_fill,
        wr_burst,
        wr_resp,
        rd_cmd,
        rd_data
    } bridge_state_e;

    // AW and AR request, 39 bits
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
    } axi_addr_req_t;

    // native command, 30 bits
    typedef struct packed {
        logic [addr_w-1:0] addr;
        app_opcode_e       cmd;
    } app_req_t;

    // AXI read beat, 261 bits
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [id_w-1:0]   id;
        logic              last;
    } axi_rbeat_t;

endpackage

// File: hdl/sync_fifo.sv
/*
 * synchronous first-word-fall-through FIFO
 * circular buffer with occupancy count, full and empty flags
 */
module sync_fifo import ddr_bridge_pkg::*; #(
    parameter int width = data_w
) (
    input  logic             clock,
    input  logic             rst,
    input  logic [width-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [width-1:0] dout,
    output logic             full,
    output logic             empty
);

    logic [width-1:0] mem [fifo_depth];
    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    // one extra bit so a full buffer is representable
    logic [fifo_aw:0] count;
    logic do_wr;
    logic do_rd;

    // writes into a full buffer and reads from an empty one are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full  = (count == (fifo_aw + 1)'(fifo_depth));
    assign empty = (count == '0);
    // head entry always visible
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at the power of two depth
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hdl/axi_wr_intake.sv
/*
 * write side: AXI W beats into the write FIFO
 * beat counting, w_ready and the controller write-data strobe
 */
module axi_wr_intake import ddr_bridge_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic [data_w-1:0] w_data,
    input  logic              w_valid,
    output logic              w_ready,
    input  logic              wdata_phase,
    input  logic              wr_burst_go,
    input  logic [cnt_w-1:0]  wr_len,
    output logic              wr_pending,
    output logic              wr_data_done,
    output logic [data_w-1:0] app_wdf_data,
    output logic              app_wdf_wren,
    input  logic              app_wdf_rdy
);

    logic fifo_full;
    logic fifo_empty;
    logic w_fire;
    logic wdf_fire;
    // AXI beats taken in, and beats handed to the controller
    logic [cnt_w-1:0] w_cnt;
    logic [cnt_w-1:0] wdf_cnt;

    // stop taking beats once the burst is complete
    assign w_ready  = wdata_phase && !fifo_full && (w_cnt != wr_len);
    assign w_fire   = w_valid && w_ready;

    // forward only in wr_burst and only beats still owed
    assign app_wdf_wren = wr_burst_go && !fifo_empty && !wr_data_done;
    assign wdf_fire     = app_wdf_wren && app_wdf_rdy;

    assign wr_pending = !fifo_empty;

    sync_fifo #(
        .width (data_w)
    ) wr_fifo_inst (
        .clock (clock),
        .rst   (rst),
        .din   (w_data),
        .wr_en (w_fire),
        .rd_en (wdf_fire),
        .dout  (app_wdf_data),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            w_cnt        <= '0;
            wdf_cnt      <= '0;
            wr_data_done <= 1'b0;
        end else if (!wdata_phase) begin
            // counters restart for the next burst
            w_cnt        <= '0;
            wdf_cnt      <= '0;
            wr_data_done <= 1'b0;
        end else begin
            if (w_fire) begin
                w_cnt <= w_cnt + 1'b1;
            end
            if (wdf_fire) begin
                wdf_cnt <= wdf_cnt + 1'b1;
                // last beat of wr_len accepted by the controller
                if (wdf_cnt == wr_len - 1'b1) begin
                    wr_data_done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/burst_sequencer.sv
/*
 * bridge FSM, AW/AR capture and alternating address readies
 * native command generation with address stepping, write response
 */
module burst_sequencer import ddr_bridge_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  axi_addr_req_t     aw,
    input  logic              aw_valid,
    output logic              aw_ready,
    input  axi_addr_req_t     ar,
    input  logic              ar_valid,
    output logic              ar_ready,
    output logic              b_valid,
    input  logic              b_ready,
    output logic [id_w-1:0]   b_id,
    output app_req_t          app_req,
    output logic              app_en,
    input  logic              app_rdy,
    input  logic              init_calib_complete,
    input  logic              wr_pending,
    input  logic              wr_data_done,
    input  logic              rd_done,
    output logic              wdata_phase,
    output logic              wr_burst_go,
    output logic [cnt_w-1:0]  wr_len,
    output logic              rdata_phase,
    output axi_addr_req_t     rd_ctx
);

    bridge_state_e state;
    bridge_state_e next_state;

    axi_addr_req_t wr_req;
    axi_addr_req_t rd_req;
    logic [addr_w-1:0] cmd_addr;
    logic [cnt_w-1:0] cmd_cnt;
    logic [len_w-1:0] cur_len;
    logic cmd_done;
    logic aw_fire;
    logic ar_fire;
    logic cmd_fire;
    logic cmd_last;

    // readies only rise in the matching idle state
    assign aw_fire  = aw_valid && aw_ready;
    assign ar_fire  = ar_valid && ar_ready;
    assign cmd_fire = app_en && app_rdy;

    // index of the final command, awlen or arlen
    assign cur_len  = (state == rd_cmd) ? rd_req.len : wr_req.len;
    assign cmd_last = cmd_fire && (cmd_cnt == cnt_w'(cur_len));

    always_comb begin
        next_state = state;
        case (state)
            calib_wait: begin
                if (init_calib_complete && app_rdy) begin
                    next_state = wr_idle;
                end
            end
            // idle states swap every cycle until a request lands
            wr_idle: begin
                next_state = aw_fire ? wr_fill : rd_idle;
            end
            rd_idle: begin
                next_state = ar_fire ? rd_cmd : wr_idle;
            end
            // wait for the first write beat to reach the FIFO head
            wr_fill: begin
                if (wr_pending) begin
                    next_state = wr_burst;
                end
            end
            // commands and data finish in either order
            wr_burst: begin
                if (cmd_done && wr_data_done) begin
                    next_state = wr_resp;
                end
            end
            wr_resp: begin
                if (b_ready) begin
                    next_state = rd_idle;
                end
            end
            rd_cmd: begin
                if (cmd_last) begin
                    next_state = rd_data;
                end
            end
            rd_data: begin
                if (rd_done) begin
                    next_state = wr_idle;
                end
            end
            default: begin
                next_state = calib_wait;
            end
        endcase
    end

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            state    <= calib_wait;
            aw_ready <= 1'b0;
            ar_ready <= 1'b0;
            cmd_cnt  <= '0;
            cmd_done <= 1'b0;
        end else begin
            state    <= next_state;
            // registered readies track the coming state
            aw_ready <= (next_state == wr_idle);
            ar_ready <= (next_state == rd_idle);
            if (state == wr_idle || state == rd_idle) begin
                cmd_cnt  <= '0;
                cmd_done <= 1'b0;
            end else if (cmd_fire) begin
                cmd_cnt <= cmd_cnt + 1'b1;
                if (cmd_last) begin
                    cmd_done <= 1'b1;
                end
            end
        end
    end

    // captured requests and running native address
    always_ff @(posedge clock) begin
        if (aw_fire) begin
            wr_req   <= aw;
            cmd_addr <= aw.addr;
        end else if (ar_fire) begin
            rd_req   <= ar;
            cmd_addr <= ar.addr;
        end else if (cmd_fire) begin
            cmd_addr <= cmd_addr + addr_w'(app_addr_step);
        end
    end

    // held until app_rdy since only an accept moves cmd_addr or cmd_done
    assign app_en = ((state == wr_burst) || (state == rd_cmd)) && !cmd_done;

    always_comb begin
        app_req.addr = cmd_addr;
        if (!app_en) begin
            app_req.cmd = app_nop;
        end else if (state == rd_cmd) begin
            app_req.cmd = app_read;
        end else begin
            app_req.cmd = app_write;
        end
    end

    // write response carries the AW id
    assign b_valid = (state == wr_resp);
    assign b_id    = wr_req.id;

    assign wdata_phase = (state == wr_fill) || (state == wr_burst);
    assign wr_burst_go = (state == wr_burst);
    assign wr_len      = cnt_w'(wr_req.len) + 1'b1;
    assign rdata_phase = (state == rd_cmd) || (state == rd_data);
    assign rd_ctx      = rd_req;

endmodule

// File: hdl/axi_rd_return.sv
/*
 * read side with the read FIFO for controller read data
 * r_valid, beat counting, r.last and burst completion
 */
module axi_rd_return import ddr_bridge_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  logic [data_w-1:0] app_rd_data,
    input  logic              app_rd_data_valid,
    input  logic              rdata_phase,
    input  axi_addr_req_t     rd_ctx,
    output axi_rbeat_t        r,
    output logic              r_valid,
    input  logic              r_ready,
    output logic              rd_done
);

    logic [data_w-1:0] fifo_dout;
    logic fifo_empty;
    logic r_fire;
    // zero-based beat index within the burst
    logic [len_w-1:0] rd_cnt;

    assign r_valid = rdata_phase && !fifo_empty;
    assign r_fire  = r_valid && r_ready;

    // depth covers a whole burst so the controller needs no back-pressure
    sync_fifo #(
        .width (data_w)
    ) rd_fifo_inst (
        .clock (clock),
        .rst   (rst),
        .din   (app_rd_data),
        .wr_en (app_rd_data_valid),
        .rd_en (r_fire),
        .dout  (fifo_dout),
        .full  (),
        .empty (fifo_empty)
    );

    assign r.data = fifo_dout;
    assign r.id   = rd_ctx.id;
    // last on beat number arlen
    assign r.last = (rd_cnt == rd_ctx.len);

    assign rd_done = r_fire && r.last;

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            rd_cnt <= '0;
        end else if (!rdata_phase) begin
            rd_cnt <= '0;
        end else if (r_fire) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

endmodule

// File: hdl/axi_ddr_bridge.sv
/*
 * AXI4 burst port to native DDR controller bridge, top level
 */
module axi_ddr_bridge import ddr_bridge_pkg::*; (
    input  logic              clock,
    input  logic              rst,
    input  axi_addr_req_t     aw,
    input  logic              aw_valid,
    output logic              aw_ready,
    input  logic [data_w-1:0] w_data,
    input  logic              w_valid,
    output logic              w_ready,
    output logic              b_valid,
    input  logic              b_ready,
    output logic [id_w-1:0]   b_id,
    input  axi_addr_req_t     ar,
    input  logic              ar_valid,
    output logic              ar_ready,
    output axi_rbeat_t        r,
    output logic              r_valid,
    input  logic              r_ready,
    output app_req_t          app_req,
    output logic              app_en,
    input  logic              app_rdy,
    output logic [data_w-1:0] app_wdf_data,
    output logic              app_wdf_wren,
    input  logic              app_wdf_rdy,
    input  logic [data_w-1:0] app_rd_data,
    input  logic              app_rd_data_valid,
    input  logic              init_calib_complete
);

    // sequencer to write side
    logic wdata_phase;
    logic wr_burst_go;
    logic [cnt_w-1:0] wr_len;
    logic wr_pending;
    logic wr_data_done;
    // sequencer to read side
    logic rdata_phase;
    axi_addr_req_t rd_ctx;
    logic rd_done;

    axi_wr_intake axi_wr_intake_inst (
        .clock        (clock),
        .rst          (rst),
        .w_data       (w_data),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .wdata_phase  (wdata_phase),
        .wr_burst_go  (wr_burst_go),
        .wr_len       (wr_len),
        .wr_pending   (wr_pending),
        .wr_data_done (wr_data_done),
        .app_wdf_data (app_wdf_data),
        .app_wdf_wren (app_wdf_wren),
        .app_wdf_rdy  (app_wdf_rdy)
    );

    burst_sequencer burst_sequencer_inst (
        .clock               (clock),
        .rst                 (rst),
        .aw                  (aw),
        .aw_valid            (aw_valid),
        .aw_ready            (aw_ready),
        .ar                  (ar),
        .ar_valid            (ar_valid),
        .ar_ready            (ar_ready),
        .b_valid             (b_valid),
        .b_ready             (b_ready),
        .b_id                (b_id),
        .app_req             (app_req),
        .app_en              (app_en),
        .app_rdy             (app_rdy),
        .init_calib_complete (init_calib_complete),
        .wr_pending          (wr_pending),
        .wr_data_done        (wr_data_done),
        .rd_done             (rd_done),
        .wdata_phase         (wdata_phase),
        .wr_burst_go         (wr_burst_go),
        .wr_len              (wr_len),
        .rdata_phase         (rdata_phase),
        .rd_ctx              (rd_ctx)
    );

    axi_rd_return axi_rd_return_inst (
        .clock             (clock),
        .rst               (rst),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .rdata_phase       (rdata_phase),
        .rd_ctx            (rd_ctx),
        .r                 (r),
        .r_valid           (r_valid),
        .r_ready           (r_ready),
        .rd_done           (rd_done)
    );

endmodule

// File: tests/axi_ddr_bridge_sva.sv
/*
 * concurrent assertions on the bridge top level, bound to axi_ddr_bridge
 */
module axi_ddr_bridge_sva import ddr_bridge_pkg::*; (
    input logic            clock,
    input logic            rst,
    input logic            aw_ready,
    input logic            ar_ready,
    input logic            b_valid,
    input logic            b_ready,
    input logic [id_w-1:0] b_id,
    input axi_rbeat_t      r,
    input logic            r_valid,
    input logic            r_ready,
    input app_req_t        app_req,
    input logic            app_en
);

    // idle states alternate, never both readies
    readies_exclusive: assert property (@(posedge clock) disable iff (rst)
        !(aw_ready && ar_ready))
        else $error("aw_ready and ar_ready high in the same cycle");

    // an enabled command always carries a real opcode
    cmd_not_nop: assert property (@(posedge clock) disable iff (rst)
        app_en |-> (app_req.cmd != app_nop))
        else $error("app_en high with app_nop on app_req");

    b_held: assert property (@(posedge clock) disable iff (rst)
        (b_valid && !b_ready) |=> (b_valid && $stable(b_id)))
        else $error("write response dropped or changed before b_ready");

    // read beat frozen under back-pressure
    r_held: assert property (@(posedge clock) disable iff (rst)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)))
        else $error("read beat dropped or changed before r_ready");

endmodule

bind axi_ddr_bridge axi_ddr_bridge_sva axi_ddr_bridge_sva_inst (.*);

// File: tests/axi_ddr_bridge_tb.sv
/*
 * testbench: AXI master, native controller model with memory,
 * reference function, checker and watchdog
 */
module axi_ddr_bridge_tb import ddr_bridge_pkg::*; ();

    localparam int num_tests = 8;

    logic clock;
    logic rst;
    axi_addr_req_t aw;
    logic aw_valid;
    logic aw_ready;
    logic [data_w-1:0] w_data;
    logic w_valid;
    logic w_ready;
    logic b_valid;
    logic b_ready;
    logic [id_w-1:0] b_id;
    axi_addr_req_t ar;
    logic ar_valid;
    logic ar_ready;
    axi_rbeat_t r;
    logic r_valid;
    logic r_ready;
    app_req_t app_req;
    logic app_en;
    logic app_rdy;
    logic [data_w-1:0] app_wdf_data;
    logic app_wdf_wren;
    logic app_wdf_rdy;
    logic [data_w-1:0] app_rd_data;
    logic app_rd_data_valid;
    logic init_calib_complete;

    logic [31:0] lfsr = 32'h4f6;
    int cycle;
    int value_errors;
    int other_errors;
    int watchdog_cycles = 0;
    int test_len [num_tests];
    // high from an AW/AR transfer until its burst closes
    logic burst_open;

    // reference memory and expected transfers in order
    logic [data_w-1:0] ref_mem [logic [addr_w-1:0]];
    app_req_t exp_cmd_q [$];
    logic [data_w-1:0] exp_wdf_q [$];
    logic [id_w-1:0] exp_b_q [$];
    axi_rbeat_t exp_r_q [$];
    // controller model state
    logic [data_w-1:0] model_mem [logic [addr_w-1:0]];
    logic [addr_w-1:0] wr_addr_q [$];
    logic [data_w-1:0] wr_data_q [$];
    logic [addr_w-1:0] rd_addr_q [$];
    int rd_due_q [$];

    axi_ddr_bridge axi_ddr_bridge_inst (.*);

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    // native address of beat idx
    function automatic logic [addr_w-1:0] expected_addr(logic [addr_w-1:0] base, int idx);
        return base + addr_w'(idx * app_addr_step);
    endfunction

    function automatic logic [data_w-1:0] beat_pattern(int t, int idx);
        logic [data_w-1:0] d;
        for (int k = 0; k < data_w / 32; k++) begin
            d[k*32 +: 32] = 32'((t << 16) | (idx << 8) | k) * 32'h9e3779b1;
        end
        return d;
    endfunction

    // contents of never written locations
    function automatic logic [data_w-1:0] fill_pattern(logic [addr_w-1:0] a);
        return {(data_w / 32){{5'b0, a} ^ 32'h5a5a_0000}};
    endfunction

    // expected read beat from the reference memory and the step rule
    function automatic axi_rbeat_t expected_rbeat(axi_addr_req_t req, int idx);
        axi_rbeat_t b;
        logic [addr_w-1:0] a;
        a = expected_addr(req.addr, idx);
        b.data = ref_mem.exists(a) ? ref_mem[a] : fill_pattern(a);
        b.id = req.id;
        b.last = (idx == int'(req.len));
        return b;
    endfunction

    task automatic value_fail(string name, logic [data_w-1:0] exp, logic [data_w-1:0] act);
        value_errors++;
        $display("[FAIL] %s expected %h actual %h", name, exp, act);
    endtask

    task automatic report_fail(string msg);
        other_errors++;
        $display("ERROR at cycle %0d: %s", cycle, msg);
    endtask

    initial clock = 1'b0;
    always #50 clock = ~clock;
    always @(posedge clock) cycle <= cycle + 1;

    // controller model and random ready/stall pattern
    always begin
        @(posedge clock);
        #10;
        app_rdy = rand_bits(2) != 0;
        app_wdf_rdy = rand_bits(2) != 0;
        r_ready = rand_bits(2) != 0;
        b_ready = rand_bits(1) != 0;
        app_rd_data_valid = 1'b0;
        // read data back in command order, after its latency
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
            app_rd_data_valid = 1'b1;
            app_rd_data = model_mem.exists(rd_addr_q[0]) ? model_mem[rd_addr_q[0]]
                                                         : fill_pattern(rd_addr_q[0]);
            rd_due_q.delete(0);
            rd_addr_q.delete(0);
        end
    end

    // checker, sampled mid-cycle where all handshakes are settled
    always @(negedge clock) begin
        if (!init_calib_complete && (aw_ready || ar_ready || w_ready || b_valid ||
                r_valid || app_en || app_wdf_wren)) begin
            report_fail("ready, valid or enable output active before calibration");
        end
        if (burst_open && (aw_ready || ar_ready)) begin
            report_fail("address ready raised while a burst is open");
        end
        if (app_en && app_rdy) begin
            if (exp_cmd_q.size() == 0) begin
                report_fail("native command with none expected");
            end else begin
                if (app_req != exp_cmd_q[0]) begin
                    value_fail("native command", data_w'(exp_cmd_q[0]), data_w'(app_req));
                end
                exp_cmd_q.delete(0);
            end
            if (app_req.cmd == app_write) begin
                wr_addr_q.push_back(app_req.addr);
            end else begin
                rd_addr_q.push_back(app_req.addr);
                rd_due_q.push_back(cycle + 3);
            end
        end
        if (app_wdf_wren && app_wdf_rdy) begin
            if (exp_wdf_q.size() == 0) begin
                report_fail("write data beat with none expected");
            end else begin
                if (app_wdf_data != exp_wdf_q[0]) begin
                    value_fail("write data", exp_wdf_q[0], app_wdf_data);
                end
                exp_wdf_q.delete(0);
            end
            wr_data_q.push_back(app_wdf_data);
        end
        // pair write commands with write data
        while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
            model_mem[wr_addr_q[0]] = wr_data_q[0];
            wr_addr_q.delete(0);
            wr_data_q.delete(0);
        end
        if (b_valid && b_ready) begin
            if (exp_b_q.size() == 0) begin
                report_fail("write response with none expected");
            end else begin
                if (b_id != exp_b_q[0]) begin
                    value_fail("write response id", data_w'(exp_b_q[0]), data_w'(b_id));
                end
                exp_b_q.delete(0);
            end
            if (exp_cmd_q.size() != 0 || exp_wdf_q.size() != 0) begin
                report_fail("write response before all commands and beats were accepted");
            end
        end
        if (r_valid && r_ready) begin
            if (exp_r_q.size() == 0) begin
                report_fail("read beat with none expected");
            end else begin
                if (r.data != exp_r_q[0].data) begin
                    value_fail("read data", exp_r_q[0].data, r.data);
                end
                if (r.id != exp_r_q[0].id) begin
                    value_fail("read id", data_w'(exp_r_q[0].id), data_w'(r.id));
                end
                if (r.last != exp_r_q[0].last) begin
                    value_fail("read last", data_w'(exp_r_q[0].last), data_w'(r.last));
                end
                exp_r_q.delete(0);
            end
        end
    end

    task automatic write_burst(int t);
        axi_addr_req_t req;
        app_req_t c;
        req.id = id_w'(t + 3);
        req.addr = addr_w'(t * 256);
        req.len = len_w'(test_len[t]);
        for (int i = 0; i <= test_len[t]; i++) begin
            c.addr = expected_addr(req.addr, i);
            c.cmd = app_write;
            exp_cmd_q.push_back(c);
            exp_wdf_q.push_back(beat_pattern(t, i));
            ref_mem[c.addr] = beat_pattern(t, i);
        end
        exp_b_q.push_back(req.id);
        aw = req;
        aw_valid = 1'b1;
        @(negedge clock);
        while (!aw_ready) @(negedge clock);
        @(posedge clock);
        #10;
        aw_valid = 1'b0;
        burst_open = 1'b1;
        for (int i = 0; i <= test_len[t]; i++) begin
            w_data = beat_pattern(t, i);
            w_valid = 1'b1;
            @(negedge clock);
            while (!w_ready) @(negedge clock);
            @(posedge clock);
            #10;
        end
        w_valid = 1'b0;
        @(negedge clock);
        while (!(b_valid && b_ready)) @(negedge clock);
        @(posedge clock);
        #10;
        burst_open = 1'b0;
    endtask

    task automatic read_burst(int t);
        axi_addr_req_t req;
        app_req_t c;
        req.id = id_w'(t + 3);
        req.addr = addr_w'(t * 256);
        req.len = len_w'(test_len[t]);
        for (int i = 0; i <= test_len[t]; i++) begin
            c.addr = expected_addr(req.addr, i);
            c.cmd = app_read;
            exp_cmd_q.push_back(c);
            exp_r_q.push_back(expected_rbeat(req, i));
        end
        ar = req;
        ar_valid = 1'b1;
        @(negedge clock);
        while (!ar_ready) @(negedge clock);
        @(posedge clock);
        #10;
        ar_valid = 1'b0;
        burst_open = 1'b1;
        @(negedge clock);
        while (!(r_valid && r_ready && r.last)) @(negedge clock);
        @(posedge clock);
        #10;
        burst_open = 1'b0;
    endtask

    initial begin
        int total_beats;
        rst = 1'b1;
        init_calib_complete = 1'b0;
        aw = '0;
        aw_valid = 1'b0;
        w_data = '0;
        w_valid = 1'b0;
        b_ready = 1'b0;
        ar = '0;
        ar_valid = 1'b0;
        r_ready = 1'b0;
        app_rdy = 1'b0;
        app_wdf_rdy = 1'b0;
        app_rd_data = '0;
        app_rd_data_valid = 1'b0;
        burst_open = 1'b0;
        value_errors = 0;
        other_errors = 0;
        cycle = 0;
        // shortest and longest first, then random lengths
        total_beats = 0;
        for (int t = 0; t < num_tests; t++) begin
            test_len[t] = (t == 0) ? 0 : (t == 1) ? 15 : rand_bits(4);
            total_beats += 2 * (test_len[t] + 1);
        end
        watchdog_cycles = total_beats * 40;
        repeat (2) @(posedge clock);
        #10;
        rst = 1'b0;
        repeat (4) @(posedge clock);
        #10;
        init_calib_complete = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            write_burst(t);
            read_burst(t);
        end
        repeat (4) @(posedge clock);
        if (exp_cmd_q.size() != 0 || exp_wdf_q.size() != 0 || exp_b_q.size() != 0 ||
                exp_r_q.size() != 0) begin
            report_fail("expected transfers never took place");
        end
        $display("run complete: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // budget of 40 cycles per beat
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: axi_ddr_bridge.f
hdl/ddr_bridge_pkg.sv
hdl/sync_fifo.sv
hdl/axi_wr_intake.sv
hdl/burst_sequencer.sv
hdl/axi_rd_return.sv
hdl/axi_ddr_bridge.sv
tests/axi_ddr_bridge_sva.sv
tests/axi_ddr_bridge_tb.sv

// File: Makefile
# Verilator build and run of the AXI to DDR bridge testbench
.PHONY: compile run clean

compile:
	verilator --binary --assert -Wno-fatal --top-module axi_ddr_bridge_tb \
		-f axi_ddr_bridge.f -o axi_ddr_bridge_sim

run: compile
	@out=$$(./obj_dir/axi_ddr_bridge_sim); echo "$$out"; \
		echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
